/* Bender.yml */
package:
  name: wbuf

sources:
  - rtl/wbuf_pkg.sv
  - rtl/wbuf_dir.sv
  - rtl/wbuf_data.sv
  - rtl/wbuf_send_fifo.sv
  - rtl/wbuf_top.sv
  - target: simulation
    files:
      - sim/tb_wbuf.sv

/* list.f */
rtl/wbuf_pkg.sv
rtl/wbuf_dir.sv
rtl/wbuf_data.sv
rtl/wbuf_send_fifo.sv
rtl/wbuf_top.sv
sim/tb_wbuf.sv

/* rtl/wbuf_data.sv */
// Line data and byte-enable storage, one line per slot, with a byte-merging write port
`timescale 1ns/10ps
`default_nettype none

module wbuf_data
    import wbuf_pkg::*;
(
    input  wire logic        clk_i,

    input  wire logic        we_i,
    input  wire logic        new_i,
    input  wire wbuf_ptr_t   ptr_i,
    input  wire wbuf_write_t write_i,

    input  wire wbuf_ptr_t   rd_ptr_i,
    output wbuf_line_t       rd_line_o,
    output wbuf_line_be_t    rd_be_o
);

    wbuf_line_t    line_q [WBUF_ENTRIES];
    wbuf_line_be_t be_q   [WBUF_ENTRIES];
    wbuf_line_t    merged_line;
    wbuf_line_be_t merged_be;
    wbuf_line_be_t base_be;
    logic [WBUF_OFFSET_WIDTH-WBUF_WORD_OFFSET-1:0] word_idx;

    assign word_idx = write_i.addr[WBUF_OFFSET_WIDTH-1:WBUF_WORD_OFFSET];

    // Fresh slot starts with nothing valid
    assign base_be = new_i ? '0 : be_q[ptr_i];

    always_comb begin
        merged_line = line_q[ptr_i];
        merged_be   = base_be;
        for (int unsigned w = 0; w < WBUF_WORDS; w++) begin
            if (w == int'(word_idx)) begin
                for (int unsigned b = 0; b < WBUF_WORD_WIDTH / 8; b++) begin
                    if (write_i.be[b]) begin
                        merged_line[w][b*8 +: 8] = write_i.data[b*8 +: 8];
                    end
                end
                merged_be[w] = base_be[w] | write_i.be;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            line_q[ptr_i] <= merged_line;
            be_q[ptr_i]   <= merged_be;
        end
    end

    // Head of the send FIFO reads straight through
    assign rd_line_o = line_q[rd_ptr_i];
    assign rd_be_o   = be_q[rd_ptr_i];

endmodule

`default_nettype wire

/* rtl/wbuf_dir.sv */
// Write buffer directory: slot states, tags and timers, write acceptance and send selection
`timescale 1ns/10ps
`default_nettype none

module wbuf_dir
    import wbuf_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rst_ni,

    input  wire logic          write_valid_i,
    input  wire wbuf_write_t   write_i,
    output logic               write_ready_o,

    input  wire wbuf_timecnt_t cfg_threshold_i,
    input  wire logic          close_all_i,

    input  wire logic          ack_i,
    input  wire wbuf_ptr_t     ack_id_i,

    output logic               push_valid_o,
    output wbuf_ptr_t          push_id_o,
    input  wire logic          push_ready_i,

    output logic               data_we_o,
    output logic               data_new_o,
    output wbuf_ptr_t          data_ptr_o,

    input  wire wbuf_ptr_t     rd_ptr_i,
    output wbuf_tag_t          rd_tag_o,

    output logic               empty_o,
    output logic               full_o
);

    wbuf_state_e   [WBUF_ENTRIES-1:0] state_q, state_d;
    wbuf_tag_t     [WBUF_ENTRIES-1:0] tag_q;
    wbuf_timecnt_t [WBUF_ENTRIES-1:0] cnt_q;
    wbuf_ptr_t                        free_ptr_q, free_ptr_d;
    wbuf_ptr_t                        send_ptr_q, send_ptr_d;
    wbuf_tag_t                        write_tag;
    wbuf_timecnt_t                    last_cnt;
    wbuf_ptr_t                        hit_open_ptr;
    logic                             hit_open;
    logic                             hit_closed;
    logic                             slot_free;
    logic                             accept;
    logic                             alloc;
    logic                             push;

    // Round-robin search for the next slot in a given state, starting after curr
    function automatic wbuf_ptr_t find_next(
            input wbuf_ptr_t                     curr,
            input wbuf_state_e [WBUF_ENTRIES-1:0] states,
            input wbuf_state_e                   target);
        wbuf_ptr_t next;
        for (int unsigned i = 1; i <= WBUF_ENTRIES; i++) begin
            next = wbuf_ptr_t'(int'(curr) + i);
            if (states[next] == target) begin
                return next;
            end
        end
        return curr;
    endfunction

    assign write_tag = write_i.addr[WBUF_PA_WIDTH-1:WBUF_OFFSET_WIDTH];
    assign last_cnt  = wbuf_timecnt_t'(cfg_threshold_i - 1'b1);
    assign rd_tag_o  = tag_q[rd_ptr_i];

    // Tag lookup; a hit on a SENT slot counts as a miss
    always_comb begin
        hit_open     = 1'b0;
        hit_closed   = 1'b0;
        hit_open_ptr = '0;
        for (int unsigned i = 0; i < WBUF_ENTRIES; i++) begin
            if (tag_q[i] == write_tag) begin
                if (state_q[i] == WBUF_OPEN) begin
                    hit_open     = 1'b1;
                    hit_open_ptr = wbuf_ptr_t'(i);
                end
                if (state_q[i] == WBUF_CLOSED) begin
                    hit_closed = 1'b1;
                end
            end
        end
    end

    // A closed line holds new writes back so that packets stay in order
    assign slot_free     = (state_q[free_ptr_q] == WBUF_FREE);
    assign write_ready_o = !hit_closed && (hit_open || slot_free);
    assign accept        = write_valid_i && write_ready_o;
    assign alloc         = accept && !hit_open;

    assign data_we_o  = accept;
    assign data_new_o = !hit_open;
    assign data_ptr_o = hit_open ? hit_open_ptr : free_ptr_q;

    assign push_valid_o = (state_q[send_ptr_q] == WBUF_CLOSED);
    assign push_id_o    = send_ptr_q;
    assign push         = push_valid_o && push_ready_i;

    always_comb begin
        state_d = state_q;
        for (int unsigned i = 0; i < WBUF_ENTRIES; i++) begin
            case (state_q[i])
                WBUF_FREE: begin
                    if (alloc && (free_ptr_q == wbuf_ptr_t'(i))) begin
                        if ((cfg_threshold_i == '0) || close_all_i) begin
                            state_d[i] = WBUF_CLOSED;
                        end else begin
                            state_d[i] = WBUF_OPEN;
                        end
                    end
                end
                WBUF_OPEN: begin
                    if (close_all_i || (cnt_q[i] == last_cnt)) begin
                        state_d[i] = WBUF_CLOSED;
                    end
                end
                WBUF_CLOSED: begin
                    if (push && (send_ptr_q == wbuf_ptr_t'(i))) begin
                        state_d[i] = WBUF_SENT;
                    end
                end
                WBUF_SENT: begin
                    if (ack_i && (ack_id_i == wbuf_ptr_t'(i))) begin
                        state_d[i] = WBUF_FREE;
                    end
                end
            endcase
        end
    end

    // Freed slot becomes the next candidate, else advance past the one just taken
    always_comb begin
        free_ptr_d = free_ptr_q;
        if (ack_i) begin
            free_ptr_d = ack_id_i;
        end else if (alloc) begin
            free_ptr_d = find_next(free_ptr_q, state_q, WBUF_FREE);
        end

        send_ptr_d = send_ptr_q;
        if (!push_valid_o || push) begin
            send_ptr_d = find_next(send_ptr_q, state_q, WBUF_CLOSED);
        end
    end

    always_comb begin
        empty_o = 1'b1;
        full_o  = 1'b1;
        for (int unsigned i = 0; i < WBUF_ENTRIES; i++) begin
            empty_o &= (state_q[i] == WBUF_FREE);
            full_o  &= (state_q[i] != WBUF_FREE);
        end
    end

    // Tag capture on allocation and the per-slot timer
    always_ff @(posedge clk_i) begin
        for (int unsigned i = 0; i < WBUF_ENTRIES; i++) begin
            if (alloc && (free_ptr_q == wbuf_ptr_t'(i))) begin
                tag_q[i] <= write_tag;
                cnt_q[i] <= '0;
            end else if ((state_q[i] == WBUF_OPEN) && (cnt_q[i] != last_cnt)) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned i = 0; i < WBUF_ENTRIES; i++) begin
                state_q[i] <= WBUF_FREE;
            end
            free_ptr_q <= '0;
            send_ptr_q <= '0;
        end else begin
            state_q    <= state_d;
            free_ptr_q <= free_ptr_d;
            send_ptr_q <= send_ptr_d;
        end
    end

    // Acks come from downstream and must name a slot that was actually sent
    ack_sent_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> (state_q[ack_id_i] == WBUF_SENT))
        else $error("wbuf_dir: ack for a slot that is not SENT");

    // Line of a slot under push is frozen, no write may land on it
    push_frozen_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> !(data_we_o && (data_ptr_o == push_id_o)))
        else $error("wbuf_dir: write to a slot that is being pushed");

endmodule

`default_nettype wire

/* rtl/wbuf_pkg.sv */
// Shared geometry, slot states and bus structs for the write buffer; imported by every RTL block
`default_nettype none

package wbuf_pkg;

    // Address and line geometry
    localparam int unsigned WBUF_PA_WIDTH      = 16;
    localparam int unsigned WBUF_WORD_WIDTH    = 32;
    localparam int unsigned WBUF_WORDS         = 2;
    localparam int unsigned WBUF_OFFSET_WIDTH  = $clog2((WBUF_WORD_WIDTH * WBUF_WORDS) / 8);
    localparam int unsigned WBUF_WORD_OFFSET   = $clog2(WBUF_WORD_WIDTH / 8);
    localparam int unsigned WBUF_TAG_WIDTH     = WBUF_PA_WIDTH - WBUF_OFFSET_WIDTH;

    // Directory sizing
    localparam int unsigned WBUF_ENTRIES       = 4;
    localparam int unsigned WBUF_PTR_WIDTH     = $clog2(WBUF_ENTRIES);
    localparam int unsigned WBUF_TIMECNT_WIDTH = 3;

    typedef logic [WBUF_PA_WIDTH-1:0]        wbuf_addr_t;
    typedef logic [WBUF_TAG_WIDTH-1:0]       wbuf_tag_t;
    typedef logic [WBUF_PTR_WIDTH-1:0]       wbuf_ptr_t;
    typedef logic [WBUF_TIMECNT_WIDTH-1:0]   wbuf_timecnt_t;
    typedef logic [WBUF_WORD_WIDTH-1:0]      wbuf_word_t;
    typedef logic [WBUF_WORD_WIDTH/8-1:0]    wbuf_be_t;

    // Word 0 sits in the low bits of a line
    typedef wbuf_word_t [WBUF_WORDS-1:0]     wbuf_line_t;
    typedef wbuf_be_t   [WBUF_WORDS-1:0]     wbuf_line_be_t;

    // Slot life cycle
    typedef enum logic [1:0] {
        WBUF_FREE   = 2'b00,
        WBUF_OPEN   = 2'b01,
        WBUF_CLOSED = 2'b10,
        WBUF_SENT   = 2'b11
    } wbuf_state_e;

    // Incoming byte-enabled word write
    typedef struct packed {
        wbuf_addr_t addr;
        wbuf_word_t data;
        wbuf_be_t   be;
    } wbuf_write_t;

    // Outgoing packet, one whole line per slot
    typedef struct packed {
        wbuf_addr_t    addr;
        wbuf_ptr_t     id;
        wbuf_line_t    line;
        wbuf_line_be_t be;
    } wbuf_send_t;

endpackage

`default_nettype wire

/* rtl/wbuf_send_fifo.sv */
// FIFO of closed slot ids waiting to leave, so packets go out in push order
`timescale 1ns/10ps
`default_nettype none

module wbuf_send_fifo
    import wbuf_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    input  wire logic      push_valid_i,
    input  wire wbuf_ptr_t push_id_i,
    output logic           push_ready_o,

    output logic           pop_valid_o,
    output wbuf_ptr_t      pop_id_o,
    input  wire logic      pop_ready_i
);

    wbuf_ptr_t             mem_q [WBUF_ENTRIES];
    wbuf_ptr_t             wr_ptr_q;
    wbuf_ptr_t             rd_ptr_q;
    logic [WBUF_PTR_WIDTH:0] count_q;
    logic                  push;
    logic                  pop;

    assign push_ready_o = (count_q != (WBUF_PTR_WIDTH + 1)'(WBUF_ENTRIES));
    assign pop_valid_o  = (count_q != '0);
    assign pop_id_o     = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

    // Depth is a power of two, so the pointers wrap by themselves
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // No push while full, so the waiting id has to stay on the input
    hold_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_valid_i && !push_ready_o) |=> (push_valid_i && $stable(push_id_i)))
        else $error("wbuf_send_fifo: id dropped while the FIFO was full");

endmodule

`default_nettype wire

/* rtl/wbuf_top.sv */
// Write buffer top level; connects directory, data store and send FIFO into one send port
`timescale 1ns/10ps
`default_nettype none

module wbuf_top
    import wbuf_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rst_ni,

    input  wire logic          write_valid_i,
    input  wire wbuf_write_t   write_i,
    output logic               write_ready_o,

    input  wire wbuf_timecnt_t cfg_threshold_i,
    input  wire logic          close_all_i,

    output logic               send_valid_o,
    output wbuf_send_t         send_o,
    input  wire logic          send_ready_i,

    input  wire logic          ack_i,
    input  wire wbuf_ptr_t     ack_id_i,

    output logic               empty_o,
    output logic               full_o
);

    logic          push_valid;
    logic          push_ready;
    wbuf_ptr_t     push_id;
    logic          data_we;
    logic          data_new;
    wbuf_ptr_t     data_ptr;
    wbuf_ptr_t     head_id;
    wbuf_tag_t     head_tag;
    wbuf_line_t    head_line;
    wbuf_line_be_t head_be;

    wbuf_dir u_dir (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .write_valid_i   (write_valid_i),
        .write_i         (write_i),
        .write_ready_o   (write_ready_o),
        .cfg_threshold_i (cfg_threshold_i),
        .close_all_i     (close_all_i),
        .ack_i           (ack_i),
        .ack_id_i        (ack_id_i),
        .push_valid_o    (push_valid),
        .push_id_o       (push_id),
        .push_ready_i    (push_ready),
        .data_we_o       (data_we),
        .data_new_o      (data_new),
        .data_ptr_o      (data_ptr),
        .rd_ptr_i        (head_id),
        .rd_tag_o        (head_tag),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    wbuf_data u_data (
        .clk_i     (clk_i),
        .we_i      (data_we),
        .new_i     (data_new),
        .ptr_i     (data_ptr),
        .write_i   (write_i),
        .rd_ptr_i  (head_id),
        .rd_line_o (head_line),
        .rd_be_o   (head_be)
    );

    wbuf_send_fifo u_send_fifo (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_valid_i (push_valid),
        .push_id_i    (push_id),
        .push_ready_o (push_ready),
        .pop_valid_o  (send_valid_o),
        .pop_id_o     (head_id),
        .pop_ready_i  (send_ready_i)
    );

    // Packet is built from the slot at the FIFO head
    always_comb begin
        send_o.addr = {head_tag, {WBUF_OFFSET_WIDTH{1'b0}}};
        send_o.id   = head_id;
        send_o.line = head_line;
        send_o.be   = head_be;
    end

endmodule

`default_nettype wire

/* sim/tb_wbuf.sv */
// Directed testbench for the write buffer top level; run the compiled list.f with tb_wbuf as top
`timescale 1ns/10ps
`default_nettype none

module tb_wbuf
    import wbuf_pkg::*;
();

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned DRIVE_DELAY     = 2;
    localparam int unsigned RESET_CYCLES    = 16;
    localparam int unsigned NUM_TESTS       = 5;
    localparam int unsigned CYCLES_PER_TEST = 200;
    localparam int unsigned WAIT_LIMIT      = 50;
    localparam int unsigned TIMEOUT_NS      =
        (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;
    localparam int unsigned LINE_BYTES      = WBUF_WORDS * WBUF_WORD_WIDTH / 8;
    localparam int unsigned WORD_BYTES      = WBUF_WORD_WIDTH / 8;

    logic          clk_i;
    logic          rst_ni;
    logic          write_valid_i;
    wbuf_write_t   write_i;
    logic          write_ready_o;
    wbuf_timecnt_t cfg_threshold_i;
    logic          close_all_i;
    logic          send_valid_o;
    wbuf_send_t    send_o;
    logic          send_ready_i;
    logic          ack_i;
    wbuf_ptr_t     ack_id_i;
    logic          empty_o;
    logic          full_o;

    integer        seed;
    int unsigned   errors;
    int unsigned   checks;

    wbuf_top DUT (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .write_valid_i   (write_valid_i),
        .write_i         (write_i),
        .write_ready_o   (write_ready_o),
        .cfg_threshold_i (cfg_threshold_i),
        .close_all_i     (close_all_i),
        .send_valid_o    (send_valid_o),
        .send_o          (send_o),
        .send_ready_i    (send_ready_i),
        .ack_i           (ack_i),
        .ack_id_i        (ack_id_i),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string msg, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [63:0] byte_mask(input logic [LINE_BYTES-1:0] be);
        logic [63:0] mask;
        for (int i = 0; i < LINE_BYTES; i++) begin
            mask[i*8 +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    function automatic wbuf_addr_t line_base(input wbuf_addr_t addr);
        return addr & ~wbuf_addr_t'((1 << WBUF_OFFSET_WIDTH) - 1);
    endfunction

    // Reference merge: enabled bytes overwrite, enables accumulate
    task automatic apply_write(inout logic [63:0] line, inout logic [LINE_BYTES-1:0] be_line,
                               input wbuf_addr_t addr, input wbuf_word_t data,
                               input wbuf_be_t be);
        int unsigned first;
        first = addr[WBUF_OFFSET_WIDTH-1:WBUF_WORD_OFFSET] * WORD_BYTES;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                line[(first + b)*8 +: 8] = data[b*8 +: 8];
                be_line[first + b]       = 1'b1;
            end
        end
    endtask

    task automatic write_word(input wbuf_addr_t addr, input wbuf_word_t data, input wbuf_be_t be);
        int unsigned waited;
        waited        = 0;
        write_valid_i = 1'b1;
        write_i.addr  = addr;
        write_i.data  = data;
        write_i.be    = be;
        @(negedge clk_i);
        while (!write_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!write_ready_o) begin
            errors++;
            $display("error at %0t: write to %h was never accepted", $time, addr);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        write_valid_i = 1'b0;
    endtask

    task automatic receive_packet(output wbuf_send_t pkt);
        int unsigned waited;
        waited       = 0;
        send_ready_i = 1'b1;
        @(negedge clk_i);
        while (!send_valid_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        pkt = send_o;
        if (!send_valid_o) begin
            errors++;
            $display("error at %0t: no packet arrived within %0d cycles", $time, WAIT_LIMIT);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        send_ready_i = 1'b0;
    endtask

    task automatic ack_slot(input wbuf_ptr_t id);
        ack_i    = 1'b1;
        ack_id_i = id;
        @(posedge clk_i);
        #DRIVE_DELAY;
        ack_i = 1'b0;
    endtask

    task automatic check_packet(input string name, input wbuf_send_t pkt, input wbuf_addr_t addr,
                                input logic [63:0] line, input logic [LINE_BYTES-1:0] be);
        logic [63:0] mask;
        mask = byte_mask(be);
        check_value({name, " address"}, pkt.addr, addr);
        check_value({name, " byte enables"}, pkt.be, be);
        check_value({name, " data"}, pkt.line & mask, line & mask);
    endtask

    task automatic single_write_test();
        wbuf_send_t            pkt;
        logic [63:0]           exp_line;
        logic [LINE_BYTES-1:0] exp_be;
        wbuf_word_t            data;
        exp_line        = '0;
        exp_be          = '0;
        data            = $random(seed);
        cfg_threshold_i = 3'd3;
        apply_write(exp_line, exp_be, 16'h1234, data, 4'b0110);
        write_word(16'h1234, data, 4'b0110);
        receive_packet(pkt);
        check_packet("single", pkt, line_base(16'h1234), exp_line, exp_be);
        ack_slot(pkt.id);
        @(negedge clk_i);
        check_value("single empty after ack", empty_o, 1'b1);
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic coalesce_test();
        wbuf_send_t            pkt;
        logic [63:0]           exp_line;
        logic [LINE_BYTES-1:0] exp_be;
        wbuf_word_t            data [3];
        wbuf_addr_t            addr [3];
        wbuf_be_t              be [3];
        logic                  extra;
        exp_line        = '0;
        exp_be          = '0;
        extra           = 1'b0;
        cfg_threshold_i = 3'd7;
        addr            = '{16'h4a08, 16'h4a0c, 16'h4a08};
        be              = '{4'b1111, 4'b0011, 4'b0110};
        // Third write lands on bytes of the first, so it has to win
        for (int i = 0; i < 3; i++) begin
            data[i] = $random(seed);
            apply_write(exp_line, exp_be, addr[i], data[i], be[i]);
            write_word(addr[i], data[i], be[i]);
        end
        receive_packet(pkt);
        check_packet("coalesce", pkt, 16'h4a08, exp_line, exp_be);
        repeat (12) begin
            @(negedge clk_i);
            extra |= send_valid_o;
        end
        check_value("coalesce extra packet", extra, 1'b0);
        @(posedge clk_i);
        #DRIVE_DELAY;
        ack_slot(pkt.id);
    endtask

    task automatic closed_line_test();
        wbuf_send_t            pkt [2];
        logic [63:0]           exp_line [2];
        logic [LINE_BYTES-1:0] exp_be [2];
        wbuf_word_t            data [2];
        for (int i = 0; i < 2; i++) begin
            exp_line[i] = '0;
            exp_be[i]   = '0;
            data[i]     = $random(seed);
        end
        cfg_threshold_i = 3'd0;
        apply_write(exp_line[0], exp_be[0], 16'h0c10, data[0], 4'b1111);
        apply_write(exp_line[1], exp_be[1], 16'h0c14, data[1], 4'b1100);
        write_word(16'h0c10, data[0], 4'b1111);
        // Line is closed right away, so the follow-up must be held back
        write_valid_i = 1'b1;
        write_i.addr  = 16'h0c14;
        write_i.data  = data[1];
        write_i.be    = 4'b1100;
        @(negedge clk_i);
        check_value("pause ready on closed line", write_ready_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DELAY;
        write_word(16'h0c14, data[1], 4'b1100);
        receive_packet(pkt[0]);
        receive_packet(pkt[1]);
        check_packet("pause first", pkt[0], 16'h0c10, exp_line[0], exp_be[0]);
        check_packet("pause second", pkt[1], 16'h0c10, exp_line[1], exp_be[1]);
        check_value("pause distinct ids", pkt[0].id != pkt[1].id, 1'b1);
        ack_slot(pkt[0].id);
        ack_slot(pkt[1].id);
    endtask

    task automatic close_all_test();
        wbuf_send_t pkt [2];
        wbuf_addr_t addr [2];
        wbuf_word_t data [2];
        addr            = '{16'h2200, 16'h330c};
        cfg_threshold_i = 3'd7;
        for (int i = 0; i < 2; i++) begin
            data[i] = $random(seed);
            write_word(addr[i], data[i], 4'b1111);
        end
        close_all_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        close_all_i = 1'b0;
        // Timers are far from the threshold, so only the forced close can hold this write back
        write_valid_i = 1'b1;
        write_i.addr  = addr[1];
        write_i.data  = data[1];
        write_i.be    = 4'b1111;
        @(negedge clk_i);
        check_value("close_all ready on closed line", write_ready_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DELAY;
        write_valid_i = 1'b0;
        for (int i = 0; i < 2; i++) begin
            logic [63:0]           exp_line;
            logic [LINE_BYTES-1:0] exp_be;
            exp_line = '0;
            exp_be   = '0;
            apply_write(exp_line, exp_be, addr[i], data[i], 4'b1111);
            receive_packet(pkt[i]);
            check_packet("close_all", pkt[i], line_base(addr[i]), exp_line, exp_be);
        end
        ack_slot(pkt[0].id);
        ack_slot(pkt[1].id);
    endtask

    task automatic full_buffer_test();
        wbuf_send_t            pkt;
        wbuf_word_t            data [WBUF_ENTRIES];
        logic [63:0]           exp_line;
        logic [LINE_BYTES-1:0] exp_be;
        cfg_threshold_i = 3'd1;
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            data[i] = $random(seed);
            write_word(16'h5000 + 16'h0100 * i, data[i], 4'b1111);
        end
        write_valid_i = 1'b1;
        write_i.addr  = 16'h6000;
        write_i.data  = $random(seed);
        write_i.be    = 4'b1111;
        @(negedge clk_i);
        check_value("full flag", full_o, 1'b1);
        check_value("full ready for new line", write_ready_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DELAY;
        write_valid_i = 1'b0;
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            exp_line = '0;
            exp_be   = '0;
            apply_write(exp_line, exp_be, 16'h5000 + 16'h0100 * i, data[i], 4'b1111);
            receive_packet(pkt);
            check_packet("full drain", pkt, 16'h5000 + 16'h0100 * i, exp_line, exp_be);
            ack_slot(pkt.id);
        end
        @(negedge clk_i);
        check_value("full empty after drain", empty_o, 1'b1);
        check_value("full flag after drain", full_o, 1'b0);
        @(posedge clk_i);
        #DRIVE_DELAY;
        // Freed slots take new lines again
        exp_line = '0;
        exp_be   = '0;
        data[0]  = $random(seed);
        apply_write(exp_line, exp_be, 16'h6004, data[0], 4'b1001);
        write_word(16'h6004, data[0], 4'b1001);
        receive_packet(pkt);
        check_packet("full reuse", pkt, 16'h6000, exp_line, exp_be);
        ack_slot(pkt.id);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $display("watchdog expired at %0t before the tests finished", $time);
        $finish;
    end

    initial begin
        seed            = 14;
        errors          = 0;
        checks          = 0;
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        write_valid_i   = 1'b0;
        write_i         = '0;
        cfg_threshold_i = 3'd3;
        close_all_i     = 1'b0;
        send_ready_i    = 1'b0;
        ack_i           = 1'b0;
        ack_id_i        = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value("reset empty", empty_o, 1'b1);
        check_value("reset full", full_o, 1'b0);
        check_value("reset send valid", send_valid_o, 1'b0);
        check_value("reset ready for new line", write_ready_o, 1'b1);
        @(posedge clk_i);
        #DRIVE_DELAY;
        single_write_test();
        coalesce_test();
        closed_line_test();
        close_all_test();
        full_buffer_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
